//--- Makefile
# Verilator build and run of the DAT-line testbench

VERILATOR ?= verilator
TOP       ?= sd_dat_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# Fails unless the pass line shows up in the simulator output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- logic/dat_block_buffer.sv
`timescale 1ns/1ps
`include "sd_dat_settings.svh"

module dat_block_buffer import sd_dat_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        write_data,
  input  logic        read_data,
  input  logic        wr_valid,
  input  data_byte_t  wr_byte,
  input  logic        rd_pop,
  input  logic        push,
  input  data_byte_t  in_byte,
  input  logic        pop,
  output logic        fifo_okay,
  output data_byte_t  rd_byte,
  output data_byte_t  out_byte,
  output fill_count_t fill_level
);

  localparam fill_count_t FULL = fill_count_t'(`SD_BLOCK_BYTES);

  data_byte_t  mem [`SD_BLOCK_BYTES];
  byte_index_t wr_idx;
  byte_index_t rd_idx;
  fill_count_t count;
  logic        full;
  logic        empty;
  logic        phy_phase;
  logic        do_push;
  logic        do_pop;
  data_byte_t  push_byte;

  assign full  = (count == FULL);
  assign empty = (count == '0);

  // Phy owns the buffer while a transfer is in flight, host otherwise
  assign phy_phase = write_data || read_data;
  assign do_push   = (phy_phase ? push : wr_valid) && !full;
  assign do_pop    = (phy_phase ? pop : rd_pop) && !empty;
  assign push_byte = phy_phase ? in_byte : wr_byte;

  assign fifo_okay  = (write_data && full) || (read_data && empty);
  assign rd_byte    = mem[rd_idx];
  assign out_byte   = mem[rd_idx];
  assign fill_level = count;

  always_ff @(posedge clock)
  begin
    if (do_push)
      mem[wr_idx] <= push_byte;
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      wr_idx <= '0;
      rd_idx <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_idx <= wr_idx + 1'b1;
      if (do_pop)
        rd_idx <= rd_idx + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  // The phy never overruns or underruns the block
  assert property (@(posedge clock) disable iff (reset)
    !(push && full) && !(pop && empty))
    else $error("phy push on full or pop on empty buffer");

endmodule

//--- logic/dat_controller.sv
`timescale 1ns/1ps

module dat_controller import sd_dat_pkg::*; (
  input  logic           clock,
  input  logic           reset,
  input  logic           new_dat,
  input  logic           write_read,
  input  logic           ack_in,
  input  logic           fifo_okay,
  sd_dat_link_if.control link,
  output logic           busy,
  output logic           transfer_complete
);

  dat_state_t state;
  dat_state_t next_state;
  logic       write_mode;
  logic       data_phase;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Next state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb
  begin
    next_state = state;
    case (state)
      RESET:
        next_state = IDLE;
      IDLE:
      begin
        if (new_dat)
          next_state = write_read ? WRITE_COMMAND : READ_COMMAND;
      end
      WRITE_COMMAND,
      READ_COMMAND:
      begin
        // Wait for the card to release the line
        if (link.serial_ready)
          next_state = CHECK_FIFO;
      end
      CHECK_FIFO:
      begin
        if (fifo_okay)
          next_state = TRANSMIT;
      end
      TRANSMIT:
      begin
        if (link.complete)
          next_state = ACK;
      end
      ACK:
      begin
        if (ack_in)
          next_state = IDLE;
      end
      default:
        next_state = IDLE;
    endcase
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      state      <= RESET;
      write_mode <= 1'b0;
    end
    else
    begin
      state <= next_state;
      // Direction is latched with the request
      if (state == IDLE && new_dat)
        write_mode <= write_read;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // State decodes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign data_phase        = (state == CHECK_FIFO) || (state == TRANSMIT);
  assign busy              = (state != RESET) && (state != IDLE);
  assign transfer_complete = (state == ACK);

  assign link.strobe     = (state == WRITE_COMMAND) || (state == READ_COMMAND) ||
                           (state == TRANSMIT);
  assign link.transmit   = (state == TRANSMIT);
  assign link.write_data = (state == WRITE_COMMAND) || (write_mode && data_phase);
  assign link.read_data  = (state == READ_COMMAND) || (!write_mode && data_phase);

  // Direction flags are exclusive
  assert property (@(posedge clock) disable iff (reset)
    !(link.write_data && link.read_data))
    else $error("write_data and read_data both high");

  // Buffer must have been ready on the cycle before the transfer opens
  assert property (@(posedge clock) disable iff (reset)
    $rose(link.transmit) |-> $past(fifo_okay))
    else $error("transmit started without fifo_okay");

  // ACK is only reached through a completed transfer
  assert property (@(posedge clock) disable iff (reset)
    transfer_complete |-> $past(link.complete) || $past(transfer_complete))
    else $error("transfer_complete outside ACK");

endmodule

//--- logic/dat_serial_phy.sv
`timescale 1ns/1ps
`include "sd_dat_settings.svh"

module dat_serial_phy import sd_dat_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        dat_in,
  input  data_byte_t  out_byte,
  sd_dat_link_if.line link,
  output logic        push,
  output logic        pop,
  output data_byte_t  in_byte,
  output logic        dat_out,
  output logic        crc_error
);

  localparam crc16_t     CRC_POLY  = 16'h1021;
  localparam bit_count_t LAST_DATA = bit_count_t'(8 * `SD_BLOCK_BYTES);
  localparam bit_count_t LAST_LOAD = bit_count_t'(8 * `SD_BLOCK_BYTES - 8);
  localparam bit_count_t LAST_CRC  = bit_count_t'(8 * `SD_BLOCK_BYTES + `SD_CRC_BITS);
  localparam bit_count_t DONE      = bit_count_t'(`SD_FRAME_BITS);

  logic [1:0] dat_hist;
  bit_count_t bit_cnt;
  crc16_t     shift_q;
  crc16_t     crc_q;
  logic       in_data;
  logic       in_crc;
  logic       advance;
  logic       tx_bit;

  function automatic crc16_t crc16_step(crc16_t crc, logic bit_in);
    logic feedback;
    feedback = crc[15] ^ bit_in;
    return {crc[14:0], 1'b0} ^ (feedback ? CRC_POLY : '0);
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame position
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign in_data = (bit_cnt != '0) && (bit_cnt <= LAST_DATA);
  assign in_crc  = (bit_cnt > LAST_DATA) && (bit_cnt <= LAST_CRC);

  // Reads sit at zero until the start bit shows up
  assign advance = link.write_data || (bit_cnt != '0) || !dat_in;

  // Card is free once the line stayed high for two samples
  assign link.serial_ready = link.write_data ? &dat_hist
                                             : (!link.transmit && bit_cnt == '0);

  // Fetch the next byte at every byte boundary of a write
  assign pop  = link.transmit && link.write_data && (bit_cnt <= LAST_LOAD) &&
                (bit_cnt[2:0] == 3'd0);
  assign push = link.transmit && link.read_data && in_data && (bit_cnt[2:0] == 3'd0);
  assign in_byte = {shift_q[6:0], dat_in};

  always_comb
  begin
    if (bit_cnt == '0)
      tx_bit = 1'b0;
    else if (in_data)
      tx_bit = shift_q[15];
    else if (in_crc)
      tx_bit = crc_q[15];
    else
      tx_bit = 1'b1;
  end

  always_ff @(posedge clock)
  begin
    if (pop)
      shift_q <= {out_byte, 8'h00};
    else if (in_data || in_crc)
      shift_q <= {shift_q[14:0], link.write_data ? 1'b0 : dat_in};
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Line control and CRC
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      dat_hist      <= '0;
      bit_cnt       <= '0;
      crc_q         <= '0;
      dat_out       <= 1'b1;
      link.complete <= 1'b0;
      crc_error     <= 1'b0;
    end
    else
    begin
      dat_hist      <= {dat_hist[0], dat_in};
      link.complete <= link.transmit && (bit_cnt == DONE);
      if (!link.transmit)
      begin
        bit_cnt <= '0;
        crc_q   <= '0;
        dat_out <= 1'b1;
      end
      else
      begin
        if (advance && bit_cnt <= DONE)
          bit_cnt <= bit_cnt + 1'b1;
        dat_out <= link.write_data ? tx_bit : 1'b1;
        if (in_data)
          crc_q <= crc16_step(crc_q, link.write_data ? shift_q[15] : dat_in);
        else if (in_crc && link.write_data)
          crc_q <= {crc_q[14:0], 1'b0};
      end
      // shift_q holds the received CRC by now
      if (link.strobe && !link.transmit)
        crc_error <= 1'b0;
      else if (link.transmit && bit_cnt == DONE)
        crc_error <= link.read_data && (shift_q != crc_q);
    end
  end

  assert property (@(posedge clock) disable iff (reset)
    link.complete |-> link.transmit)
    else $error("complete pulsed outside TRANSMIT");

endmodule

//--- logic/sd_dat_host.sv
`timescale 1ns/1ps

module sd_dat_host import sd_dat_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  // Host side
  input  logic        new_dat,
  input  logic        write_read,
  input  logic        ack_in,
  input  logic        wr_valid,
  input  data_byte_t  wr_byte,
  input  logic        rd_pop,
  output logic        busy,
  output logic        transfer_complete,
  output logic        crc_error,
  output data_byte_t  rd_byte,
  output fill_count_t fill_level,
  // DAT line
  input  logic        dat_in,
  output logic        dat_out
);

  logic       fifo_okay;
  logic       push;
  logic       pop;
  data_byte_t in_byte;
  data_byte_t out_byte;

  sd_dat_link_if link ();

  dat_controller u_dat_controller (
    .clock             (clock),
    .reset             (reset),
    .new_dat           (new_dat),
    .write_read        (write_read),
    .ack_in            (ack_in),
    .fifo_okay         (fifo_okay),
    .link              (link.control),
    .busy              (busy),
    .transfer_complete (transfer_complete)
  );

  dat_block_buffer u_dat_block_buffer (
    .clock      (clock),
    .reset      (reset),
    .write_data (link.write_data),
    .read_data  (link.read_data),
    .wr_valid   (wr_valid),
    .wr_byte    (wr_byte),
    .rd_pop     (rd_pop),
    .push       (push),
    .in_byte    (in_byte),
    .pop        (pop),
    .fifo_okay  (fifo_okay),
    .rd_byte    (rd_byte),
    .out_byte   (out_byte),
    .fill_level (fill_level)
  );

  dat_serial_phy u_dat_serial_phy (
    .clock     (clock),
    .reset     (reset),
    .dat_in    (dat_in),
    .out_byte  (out_byte),
    .link      (link.line),
    .push      (push),
    .pop       (pop),
    .in_byte   (in_byte),
    .dat_out   (dat_out),
    .crc_error (crc_error)
  );

endmodule

//--- logic/sd_dat_link_if.sv
`timescale 1ns/1ps

interface sd_dat_link_if ();

  logic strobe;
  logic write_data;
  logic read_data;
  logic transmit;
  logic serial_ready;
  logic complete;

  // Controller side
  modport control (
    output strobe, write_data, read_data, transmit,
    input  serial_ready, complete
  );

  // Phy side
  modport line (
    input  strobe, write_data, read_data, transmit,
    output serial_ready, complete
  );

endinterface

//--- logic/sd_dat_pkg.sv
`include "sd_dat_settings.svh"

package sd_dat_pkg;

  typedef logic [7:0] data_byte_t;
  typedef logic [$clog2(`SD_BLOCK_BYTES)-1:0] byte_index_t;
  typedef logic [$clog2(`SD_BLOCK_BYTES+1)-1:0] fill_count_t;
  typedef logic [$clog2(`SD_FRAME_BITS)-1:0] bit_count_t;

  // CCITT CRC over the data bits, seeded with zero
  typedef logic [`SD_CRC_BITS-1:0] crc16_t;

  typedef enum logic [2:0] {
    RESET         = 3'd0,
    IDLE          = 3'd1,
    WRITE_COMMAND = 3'd2,
    READ_COMMAND  = 3'd3,
    CHECK_FIFO    = 3'd4,
    TRANSMIT      = 3'd5,
    ACK           = 3'd6
  } dat_state_t;

endpackage

//--- logic/sd_dat_settings.svh
`ifndef SD_DAT_SETTINGS_SVH
`define SD_DAT_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Block and frame geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define SD_BLOCK_BYTES 8
`define SD_CRC_BITS 16

// Start bit, data bits, CRC and stop bit
`define SD_FRAME_BITS 82

`endif

//--- sources.f
+incdir+logic
logic/sd_dat_pkg.sv
logic/sd_dat_link_if.sv
logic/dat_controller.sv
logic/dat_block_buffer.sv
logic/dat_serial_phy.sv
logic/sd_dat_host.sv
verification/sd_dat_card_model.sv
verification/sd_dat_tb.sv

//--- verification/sd_dat_card_model.sv
`timescale 1ns/1ps

module sd_dat_card_model (
  input  logic        clock,
  input  logic        reset,
  input  logic        dat_out,
  input  logic        busy_start,
  input  logic [4:0]  busy_cycles,
  input  logic        frame_start,
  input  logic [4:0]  frame_delay,
  input  logic [79:0] frame_bits,
  input  logic        crc_flip,
  input  logic [3:0]  flip_bit,
  output logic        dat_in,
  output logic [80:0] captured,
  output logic [15:0] frame_count,
  output logic        busy_violation
);

  localparam int DRIVE_DELAY = 5;

  logic [79:0] tx_bits;
  logic        capturing;
  logic [6:0]  capture_cnt;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Line driver
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial
  begin
    dat_in = 1'b1;
    tx_bits = '0;
    forever
    begin
      @(posedge clock);
      if (busy_start && busy_cycles != '0)
      begin
        // Card busy with the line held low
        #DRIVE_DELAY dat_in = 1'b0;
        repeat (busy_cycles) @(posedge clock);
        #DRIVE_DELAY dat_in = 1'b1;
      end
      else if (frame_start)
      begin
        tx_bits = frame_bits;
        if (crc_flip)
          tx_bits[15:0] = tx_bits[15:0] ^ (16'd1 << flip_bit);
        repeat (frame_delay) @(posedge clock);
        #DRIVE_DELAY dat_in = 1'b0;
        repeat (80)
        begin
          @(posedge clock);
          #DRIVE_DELAY dat_in = tx_bits[79];
          tx_bits = tx_bits << 1;
        end
        // Stop bit and then an idle line
        @(posedge clock);
        #DRIVE_DELAY dat_in = 1'b1;
      end
    end
  end

  // Write frames are collected on falling edges where dat_out is settled
  always_ff @(negedge clock)
  begin
    if (reset)
    begin
      capturing      <= 1'b0;
      capture_cnt    <= '0;
      captured       <= '0;
      frame_count    <= '0;
      busy_violation <= 1'b0;
    end
    else
    begin
      if (!dat_out && !dat_in)
        busy_violation <= 1'b1;
      if (!capturing && !dat_out)
      begin
        capturing   <= 1'b1;
        capture_cnt <= '0;
      end
      else if (capturing)
      begin
        captured    <= {captured[79:0], dat_out};
        capture_cnt <= capture_cnt + 1'b1;
        if (capture_cnt == 7'd80)
        begin
          capturing   <= 1'b0;
          frame_count <= frame_count + 1'b1;
        end
      end
    end
  end

endmodule

//--- verification/sd_dat_tb.sv
`timescale 1ns/1ps
`include "sd_dat_settings.svh"

module sd_dat_tb import sd_dat_pkg::*; ();

  localparam int CLOCK_PERIOD     = 100;
  localparam int DRIVE_DELAY      = 5;
  localparam int DIRECTED         = 4;
  localparam int RANDOM_TRANSFERS = 20;
  localparam int TRANSFER_CYCLES  = 300;

  logic        clock;
  logic        reset;
  logic        new_dat;
  logic        write_read;
  logic        ack_in;
  logic        wr_valid;
  data_byte_t  wr_byte;
  logic        rd_pop;
  logic        busy;
  logic        transfer_complete;
  logic        crc_error;
  data_byte_t  rd_byte;
  fill_count_t fill_level;
  logic        dat_in;
  logic        dat_out;
  logic        busy_start;
  logic [4:0]  busy_cycles;
  logic        frame_start;
  logic [4:0]  frame_delay;
  logic [79:0] frame_bits;
  logic        crc_flip;
  logic [3:0]  flip_bit;
  logic [80:0] captured;
  logic [15:0] frame_count;
  logic        busy_violation;
  integer      seed;
  int          errors;
  int          checks;

  sd_dat_host u_sd_dat_host (
    .clock (clock), .reset (reset), .new_dat (new_dat), .write_read (write_read),
    .ack_in (ack_in), .wr_valid (wr_valid), .wr_byte (wr_byte), .rd_pop (rd_pop),
    .busy (busy), .transfer_complete (transfer_complete), .crc_error (crc_error),
    .rd_byte (rd_byte), .fill_level (fill_level), .dat_in (dat_in), .dat_out (dat_out)
  );

  sd_dat_card_model u_card (
    .clock (clock), .reset (reset), .dat_out (dat_out), .busy_start (busy_start),
    .busy_cycles (busy_cycles), .frame_start (frame_start), .frame_delay (frame_delay),
    .frame_bits (frame_bits), .crc_flip (crc_flip), .flip_bit (flip_bit),
    .dat_in (dat_in), .captured (captured), .frame_count (frame_count),
    .busy_violation (busy_violation)
  );

  function automatic int random_below(int limit);
    return int'($unsigned($random(seed)) % limit);
  endfunction

  // CCITT polynomial, zero seed, MSB first, one byte at a time
  function automatic logic [15:0] crc16_ccitt(logic [63:0] block);
    logic [15:0] crc;
    crc = 16'h0000;
    for (int b = 7; b >= 0; b--)
    begin
      crc = crc ^ {block[b*8 +: 8], 8'h00};
      for (int k = 0; k < 8; k++)
        crc = crc[15] ? ((crc << 1) ^ 16'h1021) : (crc << 1);
    end
    return crc;
  endfunction

  task automatic check_value(logic [63:0] actual, logic [63:0] expected, string what);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("[FAIL] t=%0t: %s, got %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #DRIVE_DELAY;
  endtask

  task automatic load_block(logic [63:0] block);
    // Byte 0 sits in the top bits
    for (int i = 7; i >= 0; i--)
    begin
      wr_valid = 1'b1;
      wr_byte = block[i*8 +: 8];
      next_cycle();
    end
    wr_valid = 1'b0;
    check_value(64'(fill_level), 64'd8, "fill level after load");
  endtask

  task automatic wait_complete();
    int waited;
    waited = 0;
    while (!transfer_complete && waited < TRANSFER_CYCLES)
    begin
      next_cycle();
      waited++;
    end
    if (!transfer_complete)
    begin
      errors++;
      $display("transfer_complete did not rise within %0d cycles", TRANSFER_CYCLES);
    end
  endtask

  task automatic finish_ack();
    int hold;
    int stray_at;
    logic [15:0] frames;
    hold = 1 + random_below(8);
    stray_at = random_below(hold);
    frames = frame_count;
    for (int i = 0; i < hold; i++)
    begin
      check_value(64'({busy, transfer_complete}), 64'd3, "busy and complete before ack");
      // A request while busy has to be ignored
      new_dat = (i == stray_at);
      write_read = 1'b1;
      next_cycle();
      new_dat = 1'b0;
    end
    ack_in = 1'b1;
    next_cycle();
    ack_in = 1'b0;
    check_value(64'({busy, transfer_complete}), 64'd0, "busy and complete after ack");
    // Long enough for a stray frame to reach the card
    repeat (`SD_FRAME_BITS + 8) next_cycle();
    check_value(64'(busy), 64'd0, "busy after stray request");
    check_value(64'(frame_count), 64'(frames), "frame count after stray request");
  endtask

  task automatic write_transfer(int busy_len);
    logic [63:0] block;
    logic [15:0] frames;
    block = {$random(seed), $random(seed)};
    load_block(block);
    frames = frame_count;
    if (busy_len > 0)
    begin
      busy_start = 1'b1;
      busy_cycles = 5'(busy_len);
      next_cycle();
      busy_start = 1'b0;
    end
    new_dat = 1'b1;
    write_read = 1'b1;
    next_cycle();
    new_dat = 1'b0;
    wait_complete();
    check_value(64'(frame_count), 64'(frames + 16'd1), "write frame count");
    check_value(captured[80:17], block, "write data bits");
    check_value(64'(captured[16:1]), 64'(crc16_ccitt(block)), "write CRC bits");
    check_value(64'(captured[0]), 64'd1, "write stop bit");
    check_value(64'(busy_violation), 64'd0, "start bit while card busy");
    finish_ack();
  endtask

  task automatic read_transfer(logic flip);
    logic [63:0] block;
    block = {$random(seed), $random(seed)};
    frame_bits = {block, crc16_ccitt(block)};
    crc_flip = flip;
    flip_bit = 4'(random_below(16));
    // At least two cycles so the start bit lands in TRANSMIT
    frame_delay = 5'(2 + random_below(16));
    frame_start = 1'b1;
    new_dat = 1'b1;
    write_read = 1'b0;
    next_cycle();
    frame_start = 1'b0;
    new_dat = 1'b0;
    wait_complete();
    check_value(64'(crc_error), 64'(flip), "read CRC error flag");
    finish_ack();
    check_value(64'(fill_level), 64'd8, "fill level after read");
    for (int i = 7; i >= 0; i--)
    begin
      check_value(64'(rd_byte), 64'(block[i*8 +: 8]), "read byte");
      rd_pop = 1'b1;
      next_cycle();
    end
    rd_pop = 1'b0;
    check_value(64'(fill_level), 64'd0, "fill level after pops");
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Clock, watchdog and test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial
  begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  initial
  begin
    #(CLOCK_PERIOD * (DIRECTED + RANDOM_TRANSFERS) * TRANSFER_CYCLES);
    $display("Watchdog expired, the DUT stopped responding");
    $display("Simulation failed");
    $finish;
  end

  initial
  begin
    seed = 77;
    errors = 0;
    checks = 0;
    reset = 1'b1;
    new_dat = 1'b0;
    write_read = 1'b0;
    ack_in = 1'b0;
    wr_valid = 1'b0;
    wr_byte = '0;
    rd_pop = 1'b0;
    busy_start = 1'b0;
    busy_cycles = '0;
    frame_start = 1'b0;
    frame_delay = '0;
    frame_bits = '0;
    crc_flip = 1'b0;
    flip_bit = '0;
    repeat (10) @(posedge clock);
    #DRIVE_DELAY;
    reset = 1'b0;
    check_value(64'({busy, transfer_complete, crc_error}), 64'd0, "status after reset");
    check_value(64'(dat_out), 64'd1, "dat_out after reset");
    check_value(64'(fill_level), 64'd0, "fill level after reset");

    write_transfer(12);
    read_transfer(1'b0);
    read_transfer(1'b1);
    write_transfer(0);
    for (int n = 0; n < RANDOM_TRANSFERS; n++)
    begin
      if (random_below(2) == 0)
        write_transfer(random_below(21));
      else
        read_transfer(random_below(4) == 0);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule
